// ==== common/execPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage package
// Word and index types, control and pipeline bundles, opcode codes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package execPkg;

   // Basic widths
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [1:0]  fwdSel_t;

   // Operand source selects
   localparam fwdSel_t fwdNone = 2'b00;
   localparam fwdSel_t fwdWb   = 2'b01;
   localparam fwdSel_t fwdMem  = 2'b10;

   localparam word_t nopInstr = 16'h0800;

   // ALU operations
   localparam logic [2:0] aluRol  = 3'd0;
   localparam logic [2:0] aluSll  = 3'd1;
   localparam logic [2:0] aluRor  = 3'd2;
   localparam logic [2:0] aluSrl  = 3'd3;
   localparam logic [2:0] aluAdd  = 3'd4;
   localparam logic [2:0] aluXor  = 3'd5;
   localparam logic [2:0] aluAndn = 3'd6;

   // B operand sources
   localparam logic [1:0] bSrcReg  = 2'd0;
   localparam logic [1:0] bSrcImm5 = 2'd1;
   localparam logic [1:0] bSrcImm8 = 2'd2;
   localparam logic [1:0] bSrcSlbi = 2'd3;

   // Result selects
   localparam logic [2:0] resAlu = 3'd0;
   localparam logic [2:0] resEq  = 3'd1;
   localparam logic [2:0] resLt  = 3'd2;
   localparam logic [2:0] resLe  = 3'd3;
   localparam logic [2:0] resCo  = 3'd4;
   localparam logic [2:0] resBtr = 3'd5;

   // Opcodes with special handling
   localparam opcode_t opSubi  = 5'b01001;
   localparam opcode_t opAndni = 5'b01011;
   localparam opcode_t opSlbi  = 5'b10010;
   localparam opcode_t opStu   = 5'b10011;
   localparam opcode_t opBtr   = 5'b11001;
   localparam opcode_t opSeq   = 5'b11100;
   localparam opcode_t opSlt   = 5'b11101;
   localparam opcode_t opSle   = 5'b11110;
   localparam opcode_t opSco   = 5'b11111;

   typedef struct packed {
      logic [2:0] aluOp;
      logic       invA;
      logic       invB;
      logic       cin;
      logic       sign;
      logic [1:0] bSrc;
      logic       zeroExt;
      logic       immSel11;
      logic [2:0] brType;
      logic       jumpReg;
      logic [2:0] resultSel;
   } exCtrl_t;

   // Execute to memory pipeline bundle
   typedef struct packed {
      word_t   instruction;
      word_t   result;
      word_t   incrPc;
      word_t   bOperand;
      word_t   storeData;
      word_t   rtData;
      regIdx_t dest;
      logic    regWrite;
      logic    unalignedError;
   } exMem_t;

endpackage

`default_nettype wire

// ==== execute/execControl.sv ====
//////////////////////////////////////////////////////////////////////
// Execute control decoder
// Maps opcode and function bits to ALU, operand and branch controls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module execControl
   import execPkg::*;
(
   input  word_t   instruction,
   output exCtrl_t ctrl
);

   opcode_t    opcode;
   logic [1:0] func;
   logic [2:0] aluSel;
   logic       regArith;
   logic       setCond;

   assign opcode   = instruction[15:11];
   assign func     = instruction[1:0];
   assign regArith = (opcode[4:1] == 4'b1101);
   assign setCond  = (opcode[4:2] == 3'b111);

   // Raw ALU select before mapping to an operation
   // Bit 2 picks arithmetic and logic over shift and rotate
   always_comb begin
      if (regArith) begin
         aluSel = {opcode[0], func};
      end else if (opcode[4:2] == 3'b101) begin
         aluSel = {1'b0, opcode[1:0]};
      end else if (opcode[4:2] == 3'b010) begin
         aluSel = {1'b1, opcode[1:0]};
      end else begin
         aluSel = 3'b100;
      end
   end

   always_comb begin
      ctrl = '0;

      ////////////////////////////////////////////////////////////////////
      // ALU controls
      ////////////////////////////////////////////////////////////////////
      if (aluSel[2]) begin
         case (aluSel[1:0])
            2'b10:   ctrl.aluOp = aluXor;
            2'b11:   ctrl.aluOp = aluAndn;
            default: ctrl.aluOp = aluAdd;
         endcase
      end else begin
         ctrl.aluOp = aluSel;
      end

      // SUB and SUBI negate Rs
      ctrl.invA = (regArith && {opcode[0], func} == 3'b101) || (opcode == opSubi);
      // ANDN, ANDNI and compares other than SCO invert B
      ctrl.invB = (regArith && {opcode[0], func} == 3'b111) || (opcode == opAndni) ||
                  (setCond && opcode != opSco);
      ctrl.cin  = ctrl.invA | ctrl.invB;
      // Carry-out compare is the only unsigned one
      ctrl.sign = (opcode != opSco);

      ////////////////////////////////////////////////////////////////////
      // Operand controls
      ////////////////////////////////////////////////////////////////////
      if (regArith || setCond || opcode[4:1] == 4'b0000) begin
         ctrl.bSrc = bSrcReg;
      end else if (opcode == opSlbi) begin
         ctrl.bSrc = bSrcSlbi;
      end else if (opcode[4:2] == 3'b010 || opcode[4:2] == 3'b101 ||
                   opcode[4:2] == 3'b100) begin
         ctrl.bSrc = bSrcImm5;
      end else begin
         ctrl.bSrc = bSrcImm8;
      end

      // XORI and ANDNI
      ctrl.zeroExt = (opcode[4:1] == 4'b0101);

      ////////////////////////////////////////////////////////////////////
      // Branch and jump controls
      ////////////////////////////////////////////////////////////////////
      // J and JAL
      ctrl.immSel11 = ({opcode[4:2], opcode[0]} == 4'b0010);
      // JR and JALR
      ctrl.jumpReg  = ({opcode[4:2], opcode[0]} == 4'b0011);
      if (opcode[4:2] == 3'b011) begin
         ctrl.brType = {1'b1, opcode[1:0]};
      end

      // Result source
      case (opcode)
         opSeq:   ctrl.resultSel = resEq;
         opSlt:   ctrl.resultSel = resLt;
         opSle:   ctrl.resultSel = resLe;
         opSco:   ctrl.resultSel = resCo;
         opBtr:   ctrl.resultSel = resBtr;
         default: ctrl.resultSel = resAlu;
      endcase
   end

   // Branch and register jump groups are disjoint
   always_comb begin
      assert (!(ctrl.brType[2] && ctrl.jumpReg))
         else $error("branch and register jump decoded together");
   end

endmodule

`default_nettype wire

// ==== execute/alu.sv ====
//////////////////////////////////////////////////////////////////////
// 16-bit ALU
// Add, logic, shift and rotate with zero and overflow flags
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module alu
   import execPkg::*;
(
   input  word_t   inA,
   input  word_t   inB,
   input  exCtrl_t ctrl,
   output word_t   result,
   output logic    zero,
   output logic    overflow
);

   word_t       a;
   word_t       b;
   logic [16:0] sum;
   logic [3:0]  shamt;
   logic [31:0] rotLeft;
   logic [31:0] rotRight;
   logic        signedOvf;

   // Conditional inversion for subtract and and-not
   assign a = ctrl.invA ? ~inA : inA;
   assign b = ctrl.invB ? ~inB : inB;

   assign sum   = {1'b0, a} + {1'b0, b} + {16'd0, ctrl.cin};
   assign shamt = inB[3:0];

   // Rotates on a doubled copy of A
   assign rotLeft  = {a, a} << shamt;
   assign rotRight = {a, a} >> shamt;

   always_comb begin
      case (ctrl.aluOp)
         aluRol:  result = rotLeft[31:16];
         aluSll:  result = a << shamt;
         aluRor:  result = rotRight[15:0];
         aluSrl:  result = a >> shamt;
         aluXor:  result = a ^ b;
         // B already inverted by the decoder
         aluAndn: result = a & b;
         default: result = sum[15:0];
      endcase
   end

   // Same input signs, different result sign
   assign signedOvf = (a[15] == b[15]) && (sum[15] != a[15]);

   assign zero     = (result == 16'h0000);
   // Carry out when unsigned
   assign overflow = ctrl.sign ? signedOvf : sum[16];

endmodule

`default_nettype wire

// ==== execute/branchUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Branch and jump unit
// Branch condition, target add, next PC and pipeline squash
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module branchUnit
   import execPkg::*;
(
   input  exCtrl_t ctrl,
   input  word_t   instruction,
   input  word_t   incrPc,
   input  word_t   aluResult,
   input  logic    zero,
   output word_t   newPc,
   output logic    pcSrc,
   output logic    squash
);

   logic  sf;
   logic  taken;
   word_t offset;
   word_t target;

   assign sf = aluResult[15];

   // Condition on Rs plus zero
   always_comb begin
      case (ctrl.brType)
         3'b100:  taken = zero;
         3'b101:  taken = ~zero;
         3'b110:  taken = sf;
         3'b111:  taken = ~sf | zero;
         default: taken = ctrl.immSel11;
      endcase
   end

   // 11-bit offset for J and JAL, 8-bit for branches
   assign offset = ctrl.immSel11 ? {{5{instruction[10]}}, instruction[10:0]}
                                 : {{8{instruction[7]}}, instruction[7:0]};
   assign target = incrPc + offset;

   assign pcSrc = taken | ctrl.jumpReg;
   assign newPc = ctrl.jumpReg ? aluResult : (taken ? target : incrPc);

   // Immediate jumps are resolved early and need no flush
   assign squash = (newPc != incrPc) && !ctrl.immSel11;

   always_comb begin
      assert (!squash || pcSrc)
         else $error("squash without a taken branch or jump");
   end

endmodule

`default_nettype wire

// ==== execute/execute.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage
// Forwarding muxes, B operand, result select, EX/MEM register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module execute
   import execPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  word_t   instruction,
   input  word_t   incrPc,
   input  word_t   aReg,
   input  word_t   bReg,
   input  regIdx_t exDest,
   input  logic    regWrite,
   input  logic    unalignedError,
   input  word_t   wbData,
   input  fwdSel_t forwardA,
   input  fwdSel_t forwardB,
   output regIdx_t rs,
   output regIdx_t rt,
   output logic    rsValid,
   output logic    rtValid,
   output word_t   newPc,
   output logic    pcSrc,
   output logic    squash,
   output exMem_t  exMemOut
);

   opcode_t opcode;
   exCtrl_t ctrl;
   word_t   aOp;
   word_t   rtOp;
   word_t   ext5;
   word_t   ext8;
   word_t   bOperand;
   word_t   aluResult;
   word_t   result;
   logic    zero;
   logic    overflow;
   logic    lessThan;
   exMem_t  exMemNext;

   // Register value, writeback data or registered execute result
   function automatic word_t pickOperand(input fwdSel_t sel, input word_t regVal);
      case (sel)
         fwdWb:   return wbData;
         fwdMem:  return exMemOut.result;
         default: return regVal;
      endcase
   endfunction

   function automatic word_t bitReverse(input word_t val);
      word_t rev;
      for (int i = 0; i < 16; i++) begin
         rev[i] = val[15 - i];
      end
      return rev;
   endfunction

   assign opcode = instruction[15:11];

   execControl i_execControl (
      .instruction (instruction),
      .ctrl        (ctrl)
   );

   //////////////////////////////////////////////////////////////////////
   // Operands
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      aOp  = pickOperand(forwardA, aReg);
      rtOp = pickOperand(forwardB, bReg);
   end

   assign ext5 = ctrl.zeroExt ? {11'd0, instruction[4:0]}
                              : {{11{instruction[4]}}, instruction[4:0]};
   assign ext8 = {{8{instruction[7]}}, instruction[7:0]};

   // Branches and BTR pass Rs through unchanged
   always_comb begin
      if (ctrl.brType[2] || opcode == opBtr) begin
         bOperand = '0;
      end else begin
         case (ctrl.bSrc)
            bSrcImm5: bOperand = ext5;
            bSrcImm8: bOperand = ext8;
            bSrcSlbi: bOperand = {aOp[7:0], instruction[7:0]};
            default:  bOperand = rtOp;
         endcase
      end
   end

   alu i_alu (
      .inA      (aOp),
      .inB      (bOperand),
      .ctrl     (ctrl),
      .result   (aluResult),
      .zero     (zero),
      .overflow (overflow)
   );

   branchUnit i_branchUnit (
      .ctrl        (ctrl),
      .instruction (instruction),
      .incrPc      (incrPc),
      .aluResult   (aluResult),
      .zero        (zero),
      .newPc       (newPc),
      .pcSrc       (pcSrc),
      .squash      (squash)
   );

   //////////////////////////////////////////////////////////////////////
   // Result select
   //////////////////////////////////////////////////////////////////////
   // Sign corrected by overflow
   assign lessThan = aluResult[15] ^ overflow;

   always_comb begin
      case (ctrl.resultSel)
         resEq:   result = {15'd0, zero};
         resLt:   result = {15'd0, lessThan};
         resLe:   result = {15'd0, lessThan | zero};
         resCo:   result = {15'd0, overflow};
         resBtr:  result = bitReverse(aluResult);
         default: result = aluResult;
      endcase
      // SLBI result is the byte pair built as the B operand
      if (opcode == opSlbi) begin
         result = bOperand;
      end
   end

   // Next pipeline bundle
   // Squash turns the slot into a NOP
   always_comb begin
      exMemNext.instruction    = squash ? nopInstr : instruction;
      exMemNext.result         = result;
      exMemNext.incrPc         = incrPc;
      // ST with update keeps the register value
      exMemNext.bOperand       = (opcode == opStu) ? rtOp : bOperand;
      exMemNext.storeData      = aOp;
      exMemNext.rtData         = rtOp;
      exMemNext.dest           = exDest;
      exMemNext.regWrite       = regWrite & ~squash;
      exMemNext.unalignedError = unalignedError;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         exMemOut <= '{instruction: nopInstr, default: '0};
      end else begin
         exMemOut <= exMemNext;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Source registers for forwarding
   //////////////////////////////////////////////////////////////////////
   assign rs = instruction[10:8];
   assign rt = instruction[7:5];
   // No Rs for 000xx or immediate jumps
   assign rsValid = (instruction[15:13] != 3'b000) &&
                    ({instruction[15:13], instruction[11]} != 4'b0010);
   assign rtValid = (instruction[15:12] == 4'b1101) || (instruction[15:13] == 3'b111);

   assert property (@(posedge clk) reset |=> !exMemOut.regWrite)
      else $error("regWrite set after reset");

endmodule

`default_nettype wire

// ==== source/forwardUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Forwarding unit
// Picks operand sources from the memory and writeback stages
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module forwardUnit
   import execPkg::*;
(
   input  regIdx_t rs,
   input  regIdx_t rt,
   input  logic    rsValid,
   input  logic    rtValid,
   input  regIdx_t memDest,
   input  logic    memRegWrite,
   input  regIdx_t wbDest,
   input  logic    wbRegWrite,
   output fwdSel_t forwardA,
   output fwdSel_t forwardB
);

   // Younger memory-stage result wins over writeback
   function automatic fwdSel_t selectSource(input regIdx_t src, input logic valid);
      if (valid && memRegWrite && memDest == src) begin
         return fwdMem;
      end else if (valid && wbRegWrite && wbDest == src) begin
         return fwdWb;
      end
      return fwdNone;
   endfunction

   always_comb begin
      forwardA = selectSource(rs, rsValid);
      forwardB = selectSource(rt, rtValid);
   end

   always_comb begin
      assert (forwardA != 2'b11 && forwardB != 2'b11)
         else $error("unused forward select code");
   end

endmodule

`default_nettype wire

// ==== source/executeTop.sv ====
//////////////////////////////////////////////////////////////////////
// Execute top level
// Execute stage with its forwarding unit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeTop
   import execPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  word_t   instruction,
   input  word_t   incrPc,
   input  word_t   aReg,
   input  word_t   bReg,
   input  regIdx_t exDest,
   input  logic    regWrite,
   input  logic    unalignedError,
   input  word_t   wbData,
   input  regIdx_t wbDest,
   input  logic    wbRegWrite,
   output word_t   newPc,
   output logic    pcSrc,
   output logic    squash,
   output exMem_t  exMemOut
);

   regIdx_t rs;
   regIdx_t rt;
   logic    rsValid;
   logic    rtValid;
   fwdSel_t forwardA;
   fwdSel_t forwardB;

   execute i_execute (
      .clk            (clk),
      .reset          (reset),
      .instruction    (instruction),
      .incrPc         (incrPc),
      .aReg           (aReg),
      .bReg           (bReg),
      .exDest         (exDest),
      .regWrite       (regWrite),
      .unalignedError (unalignedError),
      .wbData         (wbData),
      .forwardA       (forwardA),
      .forwardB       (forwardB),
      .rs             (rs),
      .rt             (rt),
      .rsValid        (rsValid),
      .rtValid        (rtValid),
      .newPc          (newPc),
      .pcSrc          (pcSrc),
      .squash         (squash),
      .exMemOut       (exMemOut)
   );

   // Memory stage is the registered execute output
   forwardUnit i_forwardUnit (
      .rs          (rs),
      .rt          (rt),
      .rsValid     (rsValid),
      .rtValid     (rtValid),
      .memDest     (exMemOut.dest),
      .memRegWrite (exMemOut.regWrite),
      .wbDest      (wbDest),
      .wbRegWrite  (wbRegWrite),
      .forwardA    (forwardA),
      .forwardB    (forwardB)
   );

endmodule

`default_nettype wire

// ==== tb/executeTopTb.sv ====
//////////////////////////////////////////////////////////////////////
// Execute top level testbench
// Random instruction stream checked against a reference model by
// concurrent assertions on the next PC and the EX/MEM register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeTopTb
   import execPkg::*;
();

   localparam int numInstr    = 2000;
   localparam int resetCycles = 10;
   localparam int numOps      = 27;

   // DUT ports
   logic    clk;
   logic    reset;
   word_t   instruction;
   word_t   incrPc;
   word_t   aReg;
   word_t   bReg;
   regIdx_t exDest;
   logic    regWrite;
   logic    unalignedError;
   word_t   wbData;
   regIdx_t wbDest;
   logic    wbRegWrite;
   word_t   newPc;
   logic    pcSrc;
   logic    squash;
   exMem_t  exMemOut;

   // Expected values driven together with the inputs
   word_t   expNewPc;
   logic    expPcSrc;
   logic    expSquash;
   exMem_t  expPipe;
   logic    checkOn;

   // Model of the EX/MEM register and of the register file
   exMem_t  memModel;
   word_t   regs [8];
   opcode_t opList [numOps];
   integer  seed;

   executeTop i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abortRun();
      $display("Something failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic reportMismatch(input string what);
      $display("MISMATCH at %0t: %s", $time, what);
      abortRun();
   endtask

   // Memory stage match first, then writeback, else the register value
   function automatic word_t forwardedValue(input regIdx_t src, input logic valid,
                                            input word_t regVal, input logic wbWr,
                                            input regIdx_t wbIdx, input word_t wbVal);
      if (valid && memModel.regWrite && memModel.dest == src) begin
         return memModel.result;
      end else if (valid && wbWr && wbIdx == src) begin
         return wbVal;
      end
      return regVal;
   endfunction

   // 0 rol, 1 sll, 2 ror, 3 srl, 4 add, 5 b minus a, 6 xor, 7 a and not b
   function automatic word_t expectedAlu(input logic [2:0] sel, input word_t a,
                                         input word_t b);
      logic [3:0] s;
      s = b[3:0];
      case (sel)
         3'd0:    return (a << s) | (a >> (5'd16 - {1'b0, s}));
         3'd1:    return a << s;
         3'd2:    return (a >> s) | (a << (5'd16 - {1'b0, s}));
         3'd3:    return a >> s;
         3'd4:    return a + b;
         3'd5:    return b - a;
         3'd6:    return a ^ b;
         default: return a & ~b;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // One cycle of stimulus and its expected response
   //////////////////////////////////////////////////////////////////////
   task automatic driveCycle(input logic inReset);
      opcode_t     op;
      int          pick;
      word_t       instr;
      word_t       pc;
      word_t       a, r;
      word_t       bOp;
      word_t       res;
      word_t       pcNext;
      word_t       wbVal;
      word_t       imm5s, imm5z, imm8s, imm11s;
      logic [16:0] sum;
      regIdx_t     rsIdx, rtIdx;
      regIdx_t     dst;
      regIdx_t     wbIdx;
      logic        rsV, rtV;
      logic        wr, ue, wbWr;
      logic        src, sq;
      exMem_t      nxt;

      pick  = int'($unsigned($random(seed)) % numOps);
      instr = {opList[5'(pick)], 11'($random(seed))};
      // Sources often name the last destination to hit forwarding
      if (($random(seed) & 1) != 0) begin
         instr[10:8] = memModel.dest;
      end
      if (($random(seed) & 1) != 0) begin
         instr[7:5] = memModel.dest;
      end
      if (inReset) begin
         instr = nopInstr;
      end
      op    = instr[15:11];
      pc    = 16'($random(seed));
      dst   = 3'($random(seed));
      wr    = inReset ? 1'b0 : 1'($random(seed));
      ue    = 1'($random(seed));
      wbVal = 16'($random(seed));
      wbIdx = 3'($random(seed));
      wbWr  = 1'($random(seed));
      if (($random(seed) & 3) == 0) begin
         wbIdx = instr[10:8];
      end

      // No Rs for 000xx and immediate jumps
      rsIdx  = instr[10:8];
      rtIdx  = instr[7:5];
      rsV    = (op[4:2] != 3'b000) && !(op[4:2] == 3'b001 && !op[0]);
      rtV    = (op[4:1] == 4'b1101) || (op[4:2] == 3'b111);
      a      = forwardedValue(rsIdx, rsV, regs[rsIdx], wbWr, wbIdx, wbVal);
      r      = forwardedValue(rtIdx, rtV, regs[rtIdx], wbWr, wbIdx, wbVal);
      imm5s  = {{11{instr[4]}}, instr[4:0]};
      imm5z  = {11'd0, instr[4:0]};
      imm8s  = {{8{instr[7]}}, instr[7:0]};
      imm11s = {{5{instr[10]}}, instr[10:0]};
      sum    = {1'b0, a} + {1'b0, r};

      // Jumps and unlisted opcodes add the 8-bit immediate
      bOp    = imm8s;
      res    = a + imm8s;
      pcNext = pc;
      src    = 1'b0;
      casez (op)
         5'b1101?: begin
            bOp = r;
            res = expectedAlu({op[0], instr[1:0]}, a, r);
         end
         5'b010??: begin
            bOp = op[1] ? imm5z : imm5s;
            res = expectedAlu({1'b1, op[1:0]}, a, bOp);
         end
         5'b101??: begin
            bOp = imm5s;
            res = expectedAlu({1'b0, op[1:0]}, a, bOp);
         end
         // SLBI shifts the Rs low byte above the immediate
         5'b10010: begin
            bOp = {a[7:0], instr[7:0]};
            res = {a[7:0], instr[7:0]};
         end
         // Load and store address
         5'b100??: begin
            bOp = imm5s;
            res = a + imm5s;
         end
         5'b111??: begin
            bOp = r;
            case (op[1:0])
               2'b00:   res = {15'd0, a == r};
               2'b01:   res = {15'd0, $signed(a) < $signed(r)};
               2'b10:   res = {15'd0, $signed(a) <= $signed(r)};
               default: res = {15'd0, sum[16]};
            endcase
         end
         5'b011??: begin
            bOp = '0;
            res = a;
            case (op[1:0])
               2'b00:   src = (a == 16'd0);
               2'b01:   src = (a != 16'd0);
               2'b10:   src = a[15];
               default: src = !a[15] || a == 16'd0;
            endcase
            pcNext = src ? pc + imm8s : pc;
         end
         // J and JAL
         5'b001?0: begin
            src    = 1'b1;
            pcNext = pc + imm11s;
         end
         // JR and JALR jump to Rs plus the immediate
         5'b001?1: begin
            src    = 1'b1;
            pcNext = res;
         end
         5'b11001: begin
            bOp = '0;
            res = {<<{a}};
         end
         default: begin
            bOp = r;
            res = a + r;
         end
      endcase
      sq = (pcNext != pc) && !(op[4:2] == 3'b001 && !op[0]);

      nxt             = '0;
      nxt.instruction = nopInstr;
      if (!inReset) begin
         nxt.instruction    = sq ? nopInstr : instr;
         nxt.result         = res;
         nxt.incrPc         = pc;
         nxt.bOperand       = (op == 5'b10011) ? r : bOp;
         nxt.storeData      = a;
         nxt.rtData         = r;
         nxt.dest           = dst;
         nxt.regWrite       = wr && !sq;
         nxt.unalignedError = ue;
      end

      reset          <= inReset;
      instruction    <= instr;
      incrPc         <= pc;
      aReg           <= regs[rsIdx];
      bReg           <= regs[rtIdx];
      exDest         <= dst;
      regWrite       <= wr;
      unalignedError <= ue;
      wbData         <= wbVal;
      wbDest         <= wbIdx;
      wbRegWrite     <= wbWr;
      expNewPc       <= pcNext;
      expPcSrc       <= src;
      expSquash      <= sq;
      // EX/MEM contents during this cycle
      expPipe        <= memModel;
      checkOn        <= 1'b1;
      memModel        = nxt;
      // Register file takes the writeback after the read
      if (wbWr) begin
         regs[wbIdx] = wbVal;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////
   resetClears: assert property (@(posedge clk) reset |=>
         (exMemOut.instruction == nopInstr && !exMemOut.regWrite &&
          !exMemOut.unalignedError))
      else reportMismatch("EX/MEM register not cleared by reset");

   nextPcMatches: assert property (@(posedge clk) disable iff (!checkOn)
         newPc == expNewPc && pcSrc == expPcSrc && squash == expSquash)
      else reportMismatch($sformatf("newPc %h pcSrc %b squash %b, expected %h %b %b",
                          newPc, pcSrc, squash, expNewPc, expPcSrc, expSquash));

   pipeMatches: assert property (@(posedge clk) disable iff (!checkOn)
         exMemOut == expPipe)
      else reportMismatch($sformatf("exMemOut %h, expected %h", exMemOut, expPipe));

   // Flushed slot carries a NOP with no write
   squashFlushes: assert property (@(posedge clk) disable iff (!checkOn)
         squash |=> (exMemOut.instruction == nopInstr && !exMemOut.regWrite))
      else reportMismatch("squashed instruction reached the EX/MEM register");

   jumpNoSquash: assert property (@(posedge clk) disable iff (!checkOn)
         (instruction[15:13] == 3'b001 && !instruction[11]) |-> !squash)
      else reportMismatch("immediate jump raised squash");

   // Watchdog for a stalled clock or a hung run
   initial begin
      #((numInstr + resetCycles + 10) * 16);
      $display("Timeout: the run did not finish in the expected time");
      abortRun();
   end

   initial begin
      seed   = 32'hc942efef;
      opList = '{5'b01000, 5'b01001, 5'b01010, 5'b01011, 5'b10100, 5'b10101,
                 5'b10110, 5'b10111, 5'b10010, 5'b10000, 5'b10001, 5'b10011,
                 5'b11010, 5'b11011, 5'b11100, 5'b11101, 5'b11110, 5'b11111,
                 5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b00100, 5'b00101,
                 5'b00110, 5'b00111, 5'b11001};
      for (int i = 0; i < 8; i++) begin
         regs[3'(i)] = 16'($random(seed));
      end
      memModel             = '0;
      memModel.instruction = nopInstr;
      reset          = 1'b1;
      instruction    = nopInstr;
      incrPc         = '0;
      aReg           = '0;
      bReg           = '0;
      exDest         = '0;
      regWrite       = 1'b0;
      unalignedError = 1'b0;
      wbData         = '0;
      wbDest         = '0;
      wbRegWrite     = 1'b0;
      checkOn        = 1'b0;

      repeat (resetCycles) begin
         @(posedge clk);
         driveCycle(1'b1);
      end
      for (int n = 0; n < numInstr; n++) begin
         @(posedge clk);
         driveCycle(1'b0);
      end
      // Last instruction meets the next PC checks on this edge
      @(posedge clk);
      // Its EX/MEM contents are compared one edge later
      expPipe <= memModel;
      @(posedge clk);
      #1;
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== executeTop.f ====
common/execPkg.sv
execute/execControl.sv
execute/alu.sv
execute/branchUnit.sv
execute/execute.sv
source/forwardUnit.sv
source/executeTop.sv
tb/executeTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module executeTopTb \
   -f executeTop.f -Mdir obj_dir -o executeTopSim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/executeTopSim > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "Result: FAIL"; exit 1; } \
   || { echo "Result: PASS"; exit 0; }
